//--- src/dcache_cfg.svh
// widths and geometry of the data cache
// one 64-bit word per line, so the offset only selects bytes
// tag width follows from the other three widths
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

`define DC_ADDR_W   32
`define DC_DATA_W   64
`define DC_OFFSET_W 3   // byte in word
`define DC_INDEX_W  6
`define DC_SETS     64

// 32 - 6 - 3 = 23
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

//--- src/dcache_pkg.sv
// shared types for the data cache and its testbench
// response codes follow AXI encoding, only OKAY and SLVERR are produced
`include "dcache_cfg.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0] dc_addr_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } dc_resp_e;

  typedef struct packed {
    logic [`DC_DATA_W-1:0]   data;
    logic [`DC_DATA_W/8-1:0] strb;
  } dc_wchan_t;

  typedef struct packed {
    logic [`DC_DATA_W-1:0] data;
    dc_resp_e              resp;
  } dc_rchan_t;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [`DC_TAG_W-1:0] tag;
  } dc_tag_entry_t;

  // answer of the tag array to one lookup
  typedef struct packed {
    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    logic                 victim_dirty;  // victim valid and dirty
    logic [`DC_TAG_W-1:0] victim_tag;
  } dc_lookup_t;

  typedef enum logic [2:0] {
    IDLE,
    HIT,
    WB_ADDR,
    WB_DATA,
    WB_RESP,
    FILL_ADDR,
    FILL_DATA
  } dc_state_e;

endpackage

//--- src/dcache_tag_array.sv
// tag, valid, dirty and lru state for both ways
// lookup is combinational; update and touch take effect at the next edge
// victim is the first invalid way, else the way named by the lru bit
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_tag_array (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`DC_INDEX_W-1:0]        lookup_index_i,
  input  logic [`DC_TAG_W-1:0]          lookup_tag_i,
  input  logic                          upd_en_i,
  input  logic                          upd_way_i,
  input  logic [`DC_INDEX_W-1:0]        upd_index_i,
  input  dcache_pkg::dc_tag_entry_t     upd_entry_i,
  input  logic                          touch_en_i,
  input  logic                          touch_way_i,
  input  logic [`DC_INDEX_W-1:0]        touch_index_i,
  output dcache_pkg::dc_lookup_t        lookup_o
);

  logic [1:0][`DC_SETS-1:0] valid_q;
  logic [1:0][`DC_SETS-1:0] dirty_q;
  logic [`DC_SETS-1:0]      lru_q;    // names the least recently used way
  logic [`DC_TAG_W-1:0]     tag_q [2][`DC_SETS];

  logic [1:0] hit_w;
  logic       victim;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      lru_q   <= '0;
    end else begin
      if (upd_en_i)
        valid_q[upd_way_i][upd_index_i] <= upd_entry_i.valid;
      if (touch_en_i)
        lru_q[touch_index_i] <= ~touch_way_i;  // other way becomes lru
    end
  end

  always_ff @(posedge clk) begin
    if (upd_en_i) begin
      dirty_q[upd_way_i][upd_index_i] <= upd_entry_i.dirty;
      tag_q[upd_way_i][upd_index_i]   <= upd_entry_i.tag;
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hit_w[w] = valid_q[w][lookup_index_i] && (tag_q[w][lookup_index_i] == lookup_tag_i);
    end
    if (!valid_q[0][lookup_index_i])
      victim = 1'b0;
    else if (!valid_q[1][lookup_index_i])
      victim = 1'b1;
    else
      victim = lru_q[lookup_index_i];
  end

  assign lookup_o.hit          = |hit_w;
  assign lookup_o.hit_way      = hit_w[1];
  assign lookup_o.victim_way   = victim;
  assign lookup_o.victim_dirty = valid_q[victim][lookup_index_i] &&
                                 dirty_q[victim][lookup_index_i];
  assign lookup_o.victim_tag   = tag_q[victim][lookup_index_i];

  // a tag may live in one way of a set only
  a_one_hit: assert property (@(posedge clk) disable iff (rst) !(hit_w[0] && hit_w[1]));

endmodule

//--- src/dcache_data_ram.sv
// behavioral stand-in for the two-way sram macro
// registered read of both ways, byte-masked write to one way
// read and write to the same index in one cycle gives the old word
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_data_ram (
  input  logic                              clk,
  input  logic                              rd_en_i,
  input  logic [`DC_INDEX_W-1:0]            rd_index_i,
  input  logic                              wr_en_i,
  input  logic                              wr_way_i,
  input  logic [`DC_INDEX_W-1:0]            wr_index_i,
  input  logic [`DC_DATA_W-1:0]             wr_data_i,
  input  logic [`DC_DATA_W/8-1:0]           wr_strb_i,
  output logic [1:0][`DC_DATA_W-1:0]        rd_q_o
);

  logic [`DC_DATA_W-1:0] mem_q [2][`DC_SETS];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < `DC_DATA_W/8; b++) begin
        if (wr_strb_i[b])
          mem_q[wr_way_i][wr_index_i][8*b +: 8] <= wr_data_i[8*b +: 8];
      end
    end
    if (rd_en_i) begin
      rd_q_o[0] <= mem_q[0][rd_index_i];
      rd_q_o[1] <= mem_q[1][rd_index_i];  // holds until next read
    end
  end

endmodule

//--- src/dcache_ctrl.sv
// blocking controller, one request in flight
// hit or miss is decided at acceptance; a miss writes back a dirty victim,
// refills, then finishes in HIT like a hit. lru is touched when r or b completes
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  // cpu side
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  dcache_pkg::dc_addr_t          ar_addr_i,
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  input  dcache_pkg::dc_addr_t          aw_addr_i,
  input  logic                          w_valid_i,
  output logic                          w_ready_o,
  input  dcache_pkg::dc_wchan_t         w_chan_i,
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output dcache_pkg::dc_rchan_t         r_chan_o,
  output logic                          b_valid_o,
  input  logic                          b_ready_i,
  output dcache_pkg::dc_resp_e          b_resp_o,
  // memory side
  output logic                          mem_ar_valid_o,
  input  logic                          mem_ar_ready_i,
  output dcache_pkg::dc_addr_t          mem_ar_addr_o,
  output logic                          mem_aw_valid_o,
  input  logic                          mem_aw_ready_i,
  output dcache_pkg::dc_addr_t          mem_aw_addr_o,
  output logic                          mem_w_valid_o,
  input  logic                          mem_w_ready_i,
  output dcache_pkg::dc_wchan_t         mem_w_chan_o,
  input  logic                          mem_r_valid_i,
  output logic                          mem_r_ready_o,
  input  dcache_pkg::dc_rchan_t         mem_r_chan_i,
  input  logic                          mem_b_valid_i,
  output logic                          mem_b_ready_o,
  input  dcache_pkg::dc_resp_e          mem_b_resp_i,
  // tag array
  output logic [`DC_INDEX_W-1:0]        lookup_index_o,
  output logic [`DC_TAG_W-1:0]          lookup_tag_o,
  input  dcache_pkg::dc_lookup_t        lookup_i,
  output logic                          upd_en_o,
  output logic                          upd_way_o,
  output logic [`DC_INDEX_W-1:0]        upd_index_o,
  output dcache_pkg::dc_tag_entry_t     upd_entry_o,
  output logic                          touch_en_o,
  output logic                          touch_way_o,
  output logic [`DC_INDEX_W-1:0]        touch_index_o,
  // data ram
  output logic                          rd_en_o,
  output logic [`DC_INDEX_W-1:0]        rd_index_o,
  input  logic [1:0][`DC_DATA_W-1:0]    rd_q_i,
  output logic                          wr_en_o,
  output logic                          wr_way_o,
  output logic [`DC_INDEX_W-1:0]        wr_index_o,
  output logic [`DC_DATA_W-1:0]         wr_data_o,
  output logic [`DC_DATA_W/8-1:0]       wr_strb_o
);

  localparam logic [`DC_OFFSET_W-1:0] NO_OFFSET = '0;

  dcache_pkg::dc_state_e state_q;
  logic                  is_wr_q;
  logic                  way_q;
  logic                  err_q;   // write-back or fill saw SLVERR
  logic [`DC_TAG_W-1:0]  tag_q;
  logic [`DC_INDEX_W-1:0] idx_q;

  dcache_pkg::dc_addr_t  acc_addr;
  logic [`DC_INDEX_W-1:0] acc_index;
  logic [`DC_TAG_W-1:0]  acc_tag;
  dcache_pkg::dc_resp_e  fill_resp;
  logic ar_fire, aw_fire, acc;
  logic r_fire, w_fire, b_fire;
  logic mem_ar_fire, mem_aw_fire, mem_w_fire, mem_r_fire, mem_b_fire;

  assign ar_ready_o = (state_q == dcache_pkg::IDLE);
  assign aw_ready_o = (state_q == dcache_pkg::IDLE) && !ar_valid_i;  // read wins

  assign ar_fire     = ar_valid_i && ar_ready_o;
  assign aw_fire     = aw_valid_i && aw_ready_o;
  assign acc         = ar_fire || aw_fire;
  assign r_fire      = r_valid_o && r_ready_i;
  assign w_fire      = w_valid_i && w_ready_o;
  assign b_fire      = b_valid_o && b_ready_i;
  assign mem_ar_fire = mem_ar_valid_o && mem_ar_ready_i;
  assign mem_aw_fire = mem_aw_valid_o && mem_aw_ready_i;
  assign mem_w_fire  = mem_w_valid_o && mem_w_ready_i;
  assign mem_r_fire  = mem_r_valid_i && mem_r_ready_o;
  assign mem_b_fire  = mem_b_valid_i && mem_b_ready_o;

  assign acc_addr  = ar_valid_i ? ar_addr_i : aw_addr_i;
  assign acc_index = acc_addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign acc_tag   = acc_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign fill_resp = (err_q || mem_r_chan_i.resp != dcache_pkg::OKAY) ?
                     dcache_pkg::SLVERR : dcache_pkg::OKAY;

  // lookup and ram read in the accepting cycle
  assign lookup_index_o = acc_index;
  assign lookup_tag_o   = acc_tag;
  assign rd_en_o        = acc;
  assign rd_index_o     = acc_index;

  // refill writes the whole word, a cpu write only its strobed bytes
  assign wr_en_o    = w_fire || mem_r_fire;
  assign wr_way_o   = way_q;
  assign wr_index_o = idx_q;
  assign wr_data_o  = mem_r_fire ? mem_r_chan_i.data : w_chan_i.data;
  assign wr_strb_o  = mem_r_fire ? '1 : w_chan_i.strb;

  assign upd_en_o          = w_fire || mem_r_fire;
  assign upd_way_o         = way_q;
  assign upd_index_o       = idx_q;
  assign upd_entry_o.valid = 1'b1;
  assign upd_entry_o.dirty = w_fire;  // clean on refill
  assign upd_entry_o.tag   = tag_q;

  assign touch_en_o    = r_fire || b_fire;
  assign touch_way_o   = way_q;
  assign touch_index_o = idx_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= dcache_pkg::IDLE;
      is_wr_q        <= 1'b0;
      way_q          <= 1'b0;
      err_q          <= 1'b0;
      r_valid_o      <= 1'b0;
      b_valid_o      <= 1'b0;
      w_ready_o      <= 1'b0;
      mem_ar_valid_o <= 1'b0;
      mem_aw_valid_o <= 1'b0;
      mem_w_valid_o  <= 1'b0;
      mem_r_ready_o  <= 1'b0;
      mem_b_ready_o  <= 1'b0;
    end else begin
      case (state_q)
        dcache_pkg::IDLE: if (acc) begin
          is_wr_q <= aw_fire;
          err_q   <= 1'b0;
          if (lookup_i.hit) begin
            way_q     <= lookup_i.hit_way;
            w_ready_o <= aw_fire;
            state_q   <= dcache_pkg::HIT;
          end else begin
            way_q <= lookup_i.victim_way;
            if (lookup_i.victim_dirty) begin
              mem_aw_valid_o <= 1'b1;
              state_q        <= dcache_pkg::WB_ADDR;
            end else begin
              mem_ar_valid_o <= 1'b1;
              state_q        <= dcache_pkg::FILL_ADDR;
            end
          end
        end
        dcache_pkg::HIT: begin
          if (is_wr_q) begin
            if (w_fire) begin
              w_ready_o <= 1'b0;
              b_valid_o <= 1'b1;
            end else if (b_fire) begin
              b_valid_o <= 1'b0;
              state_q   <= dcache_pkg::IDLE;
            end
          end else if (!r_valid_o) begin
            r_valid_o <= 1'b1;          // ram word ready now
          end else if (r_fire) begin
            r_valid_o <= 1'b0;
            state_q   <= dcache_pkg::IDLE;
          end
        end
        dcache_pkg::WB_ADDR: if (mem_aw_fire) begin
          mem_aw_valid_o <= 1'b0;
          mem_w_valid_o  <= 1'b1;
          state_q        <= dcache_pkg::WB_DATA;
        end
        dcache_pkg::WB_DATA: if (mem_w_fire) begin
          mem_w_valid_o <= 1'b0;
          mem_b_ready_o <= 1'b1;
          state_q       <= dcache_pkg::WB_RESP;
        end
        dcache_pkg::WB_RESP: if (mem_b_fire) begin
          mem_b_ready_o  <= 1'b0;
          mem_ar_valid_o <= 1'b1;
          err_q          <= (mem_b_resp_i != dcache_pkg::OKAY);
          state_q        <= dcache_pkg::FILL_ADDR;
        end
        dcache_pkg::FILL_ADDR: if (mem_ar_fire) begin
          mem_ar_valid_o <= 1'b0;
          mem_r_ready_o  <= 1'b1;
          state_q        <= dcache_pkg::FILL_DATA;
        end
        dcache_pkg::FILL_DATA: if (mem_r_fire) begin
          mem_r_ready_o <= 1'b0;
          err_q         <= (fill_resp != dcache_pkg::OKAY);
          if (is_wr_q)
            w_ready_o <= 1'b1;          // merge w over the fill
          else
            r_valid_o <= 1'b1;          // fill data goes straight back
          state_q <= dcache_pkg::HIT;
        end
        default: state_q <= dcache_pkg::IDLE;
      endcase
    end
  end

  // payload, loaded only while the matching valid is low
  always_ff @(posedge clk) begin
    if (acc) begin
      tag_q         <= acc_tag;
      idx_q         <= acc_index;
      mem_aw_addr_o <= {lookup_i.victim_tag, acc_index, NO_OFFSET};
      mem_ar_addr_o <= {acc_tag, acc_index, NO_OFFSET};
    end
    if (mem_aw_fire)
      mem_w_chan_o <= '{data: rd_q_i[way_q], strb: '1};
    if (state_q == dcache_pkg::HIT && !is_wr_q && !r_valid_o)
      r_chan_o <= '{data: rd_q_i[way_q], resp: dcache_pkg::OKAY};
    if (mem_r_fire)
      r_chan_o <= '{data: mem_r_chan_i.data, resp: fill_resp};
    if (w_fire)
      b_resp_o <= err_q ? dcache_pkg::SLVERR : dcache_pkg::OKAY;
  end

  a_mem_rw_excl: assert property (@(posedge clk) disable iff (rst)
    !(mem_ar_valid_o && mem_aw_valid_o));

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_chan_o));

endmodule

//--- src/dcache_top.sv
// two-way write-back data cache, one 64-bit word per line
// blocking: one cpu request in flight, no uncached path
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  dcache_pkg::dc_addr_t    ar_addr_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  dcache_pkg::dc_addr_t    aw_addr_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  dcache_pkg::dc_wchan_t   w_chan_i,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output dcache_pkg::dc_rchan_t   r_chan_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output dcache_pkg::dc_resp_e    b_resp_o,
  output logic                    mem_ar_valid_o,
  input  logic                    mem_ar_ready_i,
  output dcache_pkg::dc_addr_t    mem_ar_addr_o,
  output logic                    mem_aw_valid_o,
  input  logic                    mem_aw_ready_i,
  output dcache_pkg::dc_addr_t    mem_aw_addr_o,
  output logic                    mem_w_valid_o,
  input  logic                    mem_w_ready_i,
  output dcache_pkg::dc_wchan_t   mem_w_chan_o,
  input  logic                    mem_r_valid_i,
  output logic                    mem_r_ready_o,
  input  dcache_pkg::dc_rchan_t   mem_r_chan_i,
  input  logic                    mem_b_valid_i,
  output logic                    mem_b_ready_o,
  input  dcache_pkg::dc_resp_e    mem_b_resp_i
);

  logic [`DC_INDEX_W-1:0]      lookup_index;
  logic [`DC_TAG_W-1:0]        lookup_tag;
  dcache_pkg::dc_lookup_t      lookup;
  logic                        upd_en;
  logic                        upd_way;
  logic [`DC_INDEX_W-1:0]      upd_index;
  dcache_pkg::dc_tag_entry_t   upd_entry;
  logic                        touch_en;
  logic                        touch_way;
  logic [`DC_INDEX_W-1:0]      touch_index;
  logic                        rd_en;
  logic [`DC_INDEX_W-1:0]      rd_index;
  logic [1:0][`DC_DATA_W-1:0]  rd_q;
  logic                        wr_en;
  logic                        wr_way;
  logic [`DC_INDEX_W-1:0]      wr_index;
  logic [`DC_DATA_W-1:0]       wr_data;
  logic [`DC_DATA_W/8-1:0]     wr_strb;

  dcache_ctrl u_ctrl (
    .clk, .rst,
    .ar_valid_i, .ar_ready_o, .ar_addr_i,
    .aw_valid_i, .aw_ready_o, .aw_addr_i,
    .w_valid_i, .w_ready_o, .w_chan_i,
    .r_valid_o, .r_ready_i, .r_chan_o,
    .b_valid_o, .b_ready_i, .b_resp_o,
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o,
    .mem_aw_valid_o, .mem_aw_ready_i, .mem_aw_addr_o,
    .mem_w_valid_o, .mem_w_ready_i, .mem_w_chan_o,
    .mem_r_valid_i, .mem_r_ready_o, .mem_r_chan_i,
    .mem_b_valid_i, .mem_b_ready_o, .mem_b_resp_i,
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .lookup_i       (lookup),
    .upd_en_o       (upd_en),
    .upd_way_o      (upd_way),
    .upd_index_o    (upd_index),
    .upd_entry_o    (upd_entry),
    .touch_en_o     (touch_en),
    .touch_way_o    (touch_way),
    .touch_index_o  (touch_index),
    .rd_en_o        (rd_en),
    .rd_index_o     (rd_index),
    .rd_q_i         (rd_q),
    .wr_en_o        (wr_en),
    .wr_way_o       (wr_way),
    .wr_index_o     (wr_index),
    .wr_data_o      (wr_data),
    .wr_strb_o      (wr_strb)
  );

  dcache_tag_array u_tags (
    .clk, .rst,
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .upd_en_i       (upd_en),
    .upd_way_i      (upd_way),
    .upd_index_i    (upd_index),
    .upd_entry_i    (upd_entry),
    .touch_en_i     (touch_en),
    .touch_way_i    (touch_way),
    .touch_index_i  (touch_index),
    .lookup_o       (lookup)
  );

  dcache_data_ram u_data (
    .clk,
    .rd_en_i    (rd_en),
    .rd_index_i (rd_index),
    .wr_en_i    (wr_en),
    .wr_way_i   (wr_way),
    .wr_index_i (wr_index),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .rd_q_o     (rd_q)
  );

endmodule

//--- sim/dcache_mem_model.sv
// memory responder for the cache's memory side
// handles one read and one write at a time
// unwritten words read as {addr, ~addr} of the aligned word address
// go_i bits (ar, aw, w, r, b) come from the tb lfsr and let a channel move in a cycle
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_mem_model (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [4:0]                  go_i,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  dcache_pkg::dc_addr_t        ar_addr_i,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  dcache_pkg::dc_addr_t        aw_addr_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  dcache_pkg::dc_wchan_t       w_chan_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output dcache_pkg::dc_rchan_t       r_chan_o,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output dcache_pkg::dc_resp_e        b_resp_o,
  output int                          rd_count_o,
  output int                          wr_count_o,
  output dcache_pkg::dc_addr_t        last_wb_addr_o,
  output dcache_pkg::dc_wchan_t       last_wb_o
);

  localparam int DRIVE_DLY = 2;

  logic [`DC_DATA_W-1:0] mem_q [dcache_pkg::dc_addr_t];
  dcache_pkg::dc_wchan_t shadow_q [dcache_pkg::dc_addr_t];  // last write-back per word

  function automatic dcache_pkg::dc_addr_t word_addr(input dcache_pkg::dc_addr_t a);
    return {a[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
  endfunction

  function automatic logic [`DC_DATA_W-1:0] read_word(input dcache_pkg::dc_addr_t a);
    if (mem_q.exists(a))
      return mem_q[a];
    return {a, ~a};
  endfunction

  initial begin
    logic ar_fire, aw_fire, w_fire, r_fire, b_fire;
    logic rd_busy, aw_got, w_got, b_pend, in_rst;
    logic [4:0] go;
    logic [`DC_DATA_W-1:0] word;
    dcache_pkg::dc_addr_t ar_addr, aw_addr, rd_addr, wb_addr;
    dcache_pkg::dc_wchan_t w_data, wb_data;
    rd_busy = 1'b0;
    aw_got = 1'b0;
    w_got = 1'b0;
    b_pend = 1'b0;
    ar_ready_o = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o = 1'b0;
    r_valid_o = 1'b0;
    r_chan_o = '0;
    b_valid_o = 1'b0;
    b_resp_o = dcache_pkg::OKAY;
    rd_count_o = 0;
    wr_count_o = 0;
    last_wb_addr_o = '0;
    last_wb_o = '0;
    forever begin
      @(posedge clk);
      // sample everything at the edge and update a little later
      ar_fire = ar_valid_i && ar_ready_o;
      aw_fire = aw_valid_i && aw_ready_o;
      w_fire  = w_valid_i && w_ready_o;
      r_fire  = r_valid_o && r_ready_i;
      b_fire  = b_valid_o && b_ready_i;
      ar_addr = word_addr(ar_addr_i);
      aw_addr = word_addr(aw_addr_i);
      w_data  = w_chan_i;
      go      = go_i;
      in_rst  = rst;
      #DRIVE_DLY;
      if (in_rst) begin
        rd_busy = 1'b0;
        aw_got = 1'b0;
        w_got = 1'b0;
        b_pend = 1'b0;
        ar_ready_o = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o = 1'b0;
        r_valid_o = 1'b0;
        b_valid_o = 1'b0;
        rd_count_o = 0;
        wr_count_o = 0;
      end else begin
        if (r_fire) begin
          r_valid_o = 1'b0;
          rd_busy = 1'b0;
        end
        if (ar_fire) begin
          rd_busy = 1'b1;
          rd_addr = ar_addr;
          rd_count_o++;
        end
        if (b_fire)
          b_valid_o = 1'b0;
        if (aw_fire) begin
          aw_got = 1'b1;
          wb_addr = aw_addr;
        end
        if (w_fire) begin
          w_got = 1'b1;
          wb_data = w_data;
        end
        if (aw_got && w_got) begin
          word = read_word(wb_addr);
          for (int b = 0; b < `DC_DATA_W/8; b++) begin
            if (wb_data.strb[b])
              word[8*b +: 8] = wb_data.data[8*b +: 8];
          end
          mem_q[wb_addr] = word;
          shadow_q[wb_addr] = wb_data;
          last_wb_addr_o = wb_addr;
          last_wb_o = shadow_q[wb_addr];
          wr_count_o++;
          aw_got = 1'b0;
          w_got = 1'b0;
          b_pend = 1'b1;
        end
        if (rd_busy && !r_valid_o && go[3]) begin
          r_valid_o = 1'b1;
          r_chan_o = '{data: read_word(rd_addr), resp: dcache_pkg::OKAY};
        end
        if (b_pend && go[4]) begin
          b_valid_o = 1'b1;
          b_resp_o = dcache_pkg::OKAY;
          b_pend = 1'b0;
        end
        ar_ready_o = go[0] && !rd_busy;
        aw_ready_o = go[1] && !aw_got && !b_pend && !b_valid_o;
        w_ready_o  = go[2] && !w_got && !b_pend && !b_valid_o;
      end
    end
  end

endmodule

//--- sim/dcache_tb.sv
// cpu driver for dcache_top against dcache_mem_model, random stalls on all channels
// expected data comes from a reference memory built with the table
// stops at the first mismatch or timeout
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_tb;

  localparam int DRIVE_DLY  = 2;
  localparam int WAIT_LIMIT = 300;   // cycles per wait loop
  localparam dcache_pkg::dc_addr_t ADDR_A = 32'h0001_0028;  // A, B, C share set 5
  localparam dcache_pkg::dc_addr_t ADDR_B = 32'h0002_0028;
  localparam dcache_pkg::dc_addr_t ADDR_C = 32'h0003_0028;

  typedef struct {
    string                 name;
    logic                  is_wr;
    dcache_pkg::dc_addr_t  addr;
    logic [`DC_DATA_W-1:0] data;
    logic [7:0]            strb;
    logic [`DC_DATA_W-1:0] exp_data;
    int                    exp_rd;
    int                    exp_wr;
  } row_t;

  logic clk = 1'b0;
  logic rst;
  logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
  logic r_valid_o, r_ready_i, b_valid_o, b_ready_i;
  dcache_pkg::dc_addr_t  ar_addr_i, aw_addr_i, mem_ar_addr_o, mem_aw_addr_o;
  dcache_pkg::dc_wchan_t w_chan_i, mem_w_chan_o;
  dcache_pkg::dc_rchan_t r_chan_o, mem_r_chan_i;
  dcache_pkg::dc_resp_e  b_resp_o, mem_b_resp_i;
  logic mem_ar_valid_o, mem_ar_ready_i, mem_aw_valid_o, mem_aw_ready_i;
  logic mem_w_valid_o, mem_w_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic mem_b_valid_i, mem_b_ready_o;

  logic [4:0]  mem_go;
  logic        w_go;
  logic [31:0] lfsr_q;
  int mem_rd_count, mem_wr_count;
  int r_xfers = 0;
  int b_xfers = 0;
  dcache_pkg::dc_addr_t  last_wb_addr;
  dcache_pkg::dc_wchan_t last_wb;
  logic [`DC_DATA_W-1:0] ref_mem [dcache_pkg::dc_addr_t];
  row_t rows[$];

  always #20 clk = ~clk;

  dcache_top u_dut (.*);

  dcache_mem_model u_mem (
    .clk, .rst, .go_i (mem_go),
    .ar_valid_i (mem_ar_valid_o), .ar_ready_o (mem_ar_ready_i), .ar_addr_i (mem_ar_addr_o),
    .aw_valid_i (mem_aw_valid_o), .aw_ready_o (mem_aw_ready_i), .aw_addr_i (mem_aw_addr_o),
    .w_valid_i (mem_w_valid_o), .w_ready_o (mem_w_ready_i), .w_chan_i (mem_w_chan_o),
    .r_valid_o (mem_r_valid_i), .r_ready_i (mem_r_ready_o), .r_chan_o (mem_r_chan_i),
    .b_valid_o (mem_b_valid_i), .b_ready_i (mem_b_ready_o), .b_resp_o (mem_b_resp_i),
    .rd_count_o (mem_rd_count), .wr_count_o (mem_wr_count),
    .last_wb_addr_o (last_wb_addr), .last_wb_o (last_wb)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic draw_bit();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  initial begin
    lfsr_q = 32'h6166;
    mem_go = '0;
    w_go = 1'b0;
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      for (int i = 0; i < 5; i++)
        mem_go[i] = draw_bit();
      r_ready_i = draw_bit();
      b_ready_i = draw_bit();
      w_go = draw_bit();
    end
  end

  always @(posedge clk) begin
    if (!rst && r_valid_o && r_ready_i)
      r_xfers++;
    if (!rst && b_valid_o && b_ready_i)
      b_xfers++;
  end

  function automatic logic [`DC_DATA_W-1:0] ref_read(input dcache_pkg::dc_addr_t a);
    if (ref_mem.exists(a))
      return ref_mem[a];
    return {a, ~a};  // initial memory pattern
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rchan(input string name, input dcache_pkg::dc_rchan_t exp,
                             input dcache_pkg::dc_rchan_t got);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED %s expected %h/%s actual %h/%s", name,
                         exp.data, exp.resp.name(), got.data, got.resp.name()));
  endtask

  task automatic check_resp(input string name, input dcache_pkg::dc_resp_e exp,
                            input dcache_pkg::dc_resp_e got);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED %s expected %s actual %s", name,
                         exp.name(), got.name()));
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp)
      stop_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, got));
  endtask

  task automatic check_wchan(input string name, input dcache_pkg::dc_wchan_t exp,
                             input dcache_pkg::dc_wchan_t got);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED %s expected %h/%h actual %h/%h", name,
                         exp.data, exp.strb, got.data, got.strb));
  endtask

  task automatic check_addr(input string name, input dcache_pkg::dc_addr_t exp,
                            input dcache_pkg::dc_addr_t got);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, got));
  endtask

  // expected data follows the reference memory as the rows are added
  task automatic add_row(input string name, input logic is_wr, input dcache_pkg::dc_addr_t addr,
                         input logic [`DC_DATA_W-1:0] data, input logic [7:0] strb,
                         input int exp_rd, input int exp_wr);
    row_t r;
    dcache_pkg::dc_addr_t wa;
    logic [`DC_DATA_W-1:0] word;
    wa = {addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    word = ref_read(wa);
    if (is_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b])
          word[8*b +: 8] = data[8*b +: 8];
      end
      ref_mem[wa] = word;
    end
    r.name = name;
    r.is_wr = is_wr;
    r.addr = addr;
    r.data = data;
    r.strb = strb;
    r.exp_data = word;
    r.exp_rd = exp_rd;
    r.exp_wr = exp_wr;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row("rd_miss",     0, 32'h0000_1008, '0, 8'h00, 1, 0);
    add_row("rd_hit",      0, 32'h0000_1008, '0, 8'h00, 0, 0);
    add_row("wr_hit",      1, 32'h0000_100c, 64'ha5a5_5a5a_1234_5678, 8'h0f, 0, 0);
    add_row("rd_merged",   0, 32'h0000_1008, '0, 8'h00, 0, 0);
    add_row("wr_miss",     1, 32'h0000_2010, 64'hdead_beef_0bad_f00d, 8'hf0, 1, 0);
    add_row("rd_wr_miss",  0, 32'h0000_2010, '0, 8'h00, 0, 0);
    add_row("lru_wr_a",    1, ADDR_A, 64'h0123_4567_89ab_cdef, 8'h3c, 1, 0);
    add_row("lru_rd_b",    0, ADDR_B, '0, 8'h00, 1, 0);
    add_row("lru_rd_c",    0, ADDR_C, '0, 8'h00, 1, 1);   // evicts dirty A
    add_row("lru_rd_a",    0, ADDR_A, '0, 8'h00, 1, 0);
    add_row("wr_hit_full", 1, 32'h0000_2010, 64'h5555_aaaa_3333_cccc, 8'hff, 0, 0);
    add_row("rd_full",     0, 32'h0000_2010, '0, 8'h00, 0, 0);
  endtask

  task automatic do_read(input row_t row);
    int waited;
    dcache_pkg::dc_rchan_t got;
    ar_valid_i = 1'b1;
    ar_addr_i = row.addr;
    waited = 0;
    @(posedge clk);
    while (!ar_ready_o) begin
      if (++waited > WAIT_LIMIT)
        stop_run({"read address was never accepted in ", row.name});
      @(posedge clk);
    end
    #DRIVE_DLY;
    ar_valid_i = 1'b0;
    waited = 0;
    @(posedge clk);
    while (!(r_valid_o && r_ready_i)) begin
      if (++waited > WAIT_LIMIT)
        stop_run({"read data never came back in ", row.name});
      @(posedge clk);
    end
    got = r_chan_o;
    #DRIVE_DLY;
    check_rchan(row.name, '{data: row.exp_data, resp: dcache_pkg::OKAY}, got);
  endtask

  task automatic do_write(input row_t row);
    int waited;
    dcache_pkg::dc_resp_e got;
    aw_valid_i = 1'b1;
    aw_addr_i = row.addr;
    waited = 0;
    @(posedge clk);
    while (!aw_ready_o) begin
      if (++waited > WAIT_LIMIT)
        stop_run({"write address was never accepted in ", row.name});
      @(posedge clk);
    end
    #DRIVE_DLY;
    aw_valid_i = 1'b0;
    waited = 0;
    @(posedge clk);
    while (!w_go) begin              // random gap before w
      if (++waited > WAIT_LIMIT)
        stop_run({"random gap before write data never ended in ", row.name});
      @(posedge clk);
    end
    #DRIVE_DLY;
    w_valid_i = 1'b1;
    w_chan_i = '{data: row.data, strb: row.strb};
    waited = 0;
    @(posedge clk);
    while (!w_ready_o) begin
      if (++waited > WAIT_LIMIT)
        stop_run({"write data was never accepted in ", row.name});
      @(posedge clk);
    end
    #DRIVE_DLY;
    w_valid_i = 1'b0;
    waited = 0;
    @(posedge clk);
    while (!(b_valid_o && b_ready_i)) begin
      if (++waited > WAIT_LIMIT)
        stop_run({"write response never came back in ", row.name});
      @(posedge clk);
    end
    got = b_resp_o;
    #DRIVE_DLY;
    check_resp(row.name, dcache_pkg::OKAY, got);
  endtask

  initial begin
    int rd_before, wr_before, n_r, n_b;
    rst = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    w_valid_i = 1'b0;
    w_chan_i = '0;
    n_r = 0;
    n_b = 0;
    build_table();
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    foreach (rows[i]) begin
      check_count({rows[i].name, " r transfers before"}, n_r, r_xfers);
      check_count({rows[i].name, " b transfers before"}, n_b, b_xfers);
      rd_before = mem_rd_count;
      wr_before = mem_wr_count;
      if (rows[i].is_wr) begin
        do_write(rows[i]);
        n_b++;
      end else begin
        do_read(rows[i]);
        n_r++;
      end
      check_count({rows[i].name, " memory reads"}, rows[i].exp_rd, mem_rd_count - rd_before);
      check_count({rows[i].name, " memory writes"}, rows[i].exp_wr, mem_wr_count - wr_before);
    end
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    check_count("total r transfers", n_r, r_xfers);
    check_count("total b transfers", n_b, b_xfers);
    // A was the only eviction, shadow holds its merged word with full strobe
    check_addr("write-back address", ADDR_A, last_wb_addr);
    check_wchan("write-back of A", '{data: ref_read(ADDR_A), strb: 8'hff}, last_wb);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- dcache.f
+incdir+src
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_ram.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := dcache_tb
FILELIST  := dcache.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the simulator status is not trusted, the log is
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'TEST OK' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
